/* rtl/link_test_pkg.sv */
`default_nettype none

package link_test_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	localparam int unsigned NUM_LANES   = 2;   // serial lanes under test
	localparam int unsigned DATA_W      = 32;  // bus and stream word
	localparam int unsigned ADDR_W      = 16;  // register address
	localparam int unsigned PKT_WORDS   = 3;   // words per packet, also history depth
	localparam int unsigned PKT_IDX_W   = $clog2(PKT_WORDS);
	localparam int unsigned LINK_STAT_W = 5;   // hard, soft, frame err, lane up, channel up
	localparam int unsigned STAT_W      = 8;   // tx_ready, rx_valid, rx_last, link status

	////////////////////////////////////////////////////////////
	// register map
	localparam logic [ADDR_W-1:0] ADDR_LANE_EN    = 16'h0020; // bit n enables lane n
	localparam logic [ADDR_W-1:0] ADDR_SOFT_RESET = 16'h0030; // bit 0 is the level
	localparam logic [ADDR_W-1:0] ADDR_LATENCY    = 16'h0013; // plus lane number

	localparam logic [ADDR_W-1:0] LANE_BASE   = 16'h0020;
	localparam int unsigned       LANE_STRIDE = 16'h0010;

	// offsets inside a lane window
	localparam int unsigned OFS_PKT_WORD  = 1; // 1..3
	localparam int unsigned OFS_RX_HIST   = 4; // 4 oldest .. 6 newest
	localparam int unsigned OFS_STAT_HIST = 7; // 7 oldest .. 9 newest

	// address of an offset in a lane window
	function automatic logic [ADDR_W-1:0] lane_addr(input int unsigned lane,
		input int unsigned ofs);
		return ADDR_W'(LANE_BASE + lane * LANE_STRIDE + ofs);
	endfunction

	////////////////////////////////////////////////////////////
	// packet sender states
	typedef enum logic [1:0] {
		SEND_IDLE, // wait for enable
		SEND_WORD, // words on the stream, index in a counter
		SEND_DONE  // packet out, wait for enable low
	} sender_state_t;

endpackage

`default_nettype wire

/* rtl/lane_if.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// per lane configuration, written by the register block
interface lane_cfg_if import link_test_pkg::*; ();

	logic [DATA_W-1:0] pkt_word [PKT_WORDS]; // packet payload, word 0 goes first
	logic              enable;               // start a packet
	logic              soft_reset;           // shared, held while bit is set

	modport regs (
		output pkt_word,
		output enable,
		output soft_reset
	);

	modport lane (
		input pkt_word,
		input enable,
		input soft_reset
	);

	// readback of the packet words only
	modport rdbk (
		input pkt_word
	);

endinterface

////////////////////////////////////////////////////////////
// per lane results back to the read mux
interface lane_rdbk_if import link_test_pkg::*; ();

	logic [DATA_W-1:0] rx_hist   [PKT_WORDS]; // index 0 oldest
	logic [STAT_W-1:0] stat_hist [PKT_WORDS]; // same order
	logic [DATA_W-1:0] latency;               // io_clk cycles

	modport lane (output rx_hist, output stat_hist, output latency);
	modport rdbk (input rx_hist, input stat_hist, input latency);

endinterface

`default_nettype wire

/* rtl/link_test_regs.sv */
`default_nettype none

module link_test_regs import link_test_pkg::*; (
	input  wire logic              io_clk,
	input  wire logic              reset,
	input  wire logic              io_sel,
	input  wire logic              io_sync,
	input  wire logic [ADDR_W-1:0] io_addr,
	input  wire logic              io_wr_en,
	input  wire logic [DATA_W-1:0] io_wr_data,
	lane_cfg_if.regs               cfg [NUM_LANES]
);

	logic                 wr_req;         // qualified write strobe
	logic [NUM_LANES-1:0] lane_en_q;      // one enable bit per lane
	logic                 soft_reset_q;   // senders and timers
	logic [DATA_W-1:0]    pkt_word_q [NUM_LANES][PKT_WORDS];

	assign wr_req = io_sync & io_sel & io_wr_en;

	////////////////////////////////////////////////////////////
	// write decode
	always_ff @(posedge io_clk) begin
		if (reset) begin
			lane_en_q    <= '0;
			soft_reset_q <= 1'b0;
			for (int n = 0; n < NUM_LANES; n++) begin
				for (int w = 0; w < PKT_WORDS; w++) begin
					pkt_word_q[n][w] <= '0;
				end
			end
		end else if (wr_req) begin
			if (io_addr == ADDR_LANE_EN)
				lane_en_q <= io_wr_data[NUM_LANES-1:0]; // upper bits ignored
			if (io_addr == ADDR_SOFT_RESET)
				soft_reset_q <= io_wr_data[0];
			// packet words at offsets 1..3 of each lane window
			for (int n = 0; n < NUM_LANES; n++) begin
				for (int w = 0; w < PKT_WORDS; w++) begin
					if (io_addr == lane_addr(n, OFS_PKT_WORD + w))
						pkt_word_q[n][w] <= io_wr_data;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// fan out to the lanes
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_cfg
		assign cfg[n].pkt_word   = pkt_word_q[n];
		assign cfg[n].enable     = lane_en_q[n];
		assign cfg[n].soft_reset = soft_reset_q; // same level for every lane
	end

endmodule

`default_nettype wire

/* rtl/packet_sender.sv */
`default_nettype none

module packet_sender import link_test_pkg::*; (
	input  wire logic              io_clk,
	input  wire logic              reset,
	lane_cfg_if.lane               cfg,
	input  wire logic              tx_ready,
	output logic      [DATA_W-1:0] tx_data,
	output logic                   tx_valid,
	output logic                   tx_last,
	output logic                   first_beat  // first word accepted this cycle
);

	sender_state_t        state_q;
	logic [PKT_IDX_W-1:0] idx_q;      // word on the stream
	logic                 clear;      // hard or soft reset
	logic                 xfer;       // valid and ready
	logic                 last_word;

	assign clear     = reset | cfg.soft_reset;
	assign last_word = (idx_q == PKT_IDX_W'(PKT_WORDS - 1));

	// outputs straight from state, so they hold under back-pressure
	assign tx_valid   = (state_q == SEND_WORD);
	assign tx_data    = cfg.pkt_word[idx_q];
	assign tx_last    = tx_valid & last_word;  // third word only
	assign xfer       = tx_valid & tx_ready;
	assign first_beat = xfer & (idx_q == '0);

	////////////////////////////////////////////////////////////
	// sender FSM
	always_ff @(posedge io_clk) begin
		if (clear) begin
			state_q <= SEND_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				SEND_IDLE: begin
					if (cfg.enable) begin  // go on the next cycle
						state_q <= SEND_WORD;
						idx_q   <= '0;
					end
				end
				SEND_WORD: begin
					if (xfer) begin
						if (last_word)
							state_q <= SEND_DONE;
						else
							idx_q <= idx_q + 1'b1;  // next word
					end
				end
				SEND_DONE: begin
					// one packet per enable, rearm on a low enable
					if (!cfg.enable)
						state_q <= SEND_IDLE;
				end
				default: state_q <= SEND_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/link_lane.sv */
`default_nettype none

module link_lane import link_test_pkg::*; (
	input  wire logic                   io_clk,
	input  wire logic                   reset,
	lane_cfg_if.lane                    cfg,
	lane_rdbk_if.lane                   rdbk,
	// tx stream
	output logic      [DATA_W-1:0]      tx_data,
	output logic                        tx_valid,
	output logic                        tx_last,
	input  wire logic                   tx_ready,
	// rx stream, no ready
	input  wire logic [DATA_W-1:0]      rx_data,
	input  wire logic                   rx_valid,
	input  wire logic                   rx_last,
	input  wire logic [LINK_STAT_W-1:0] link_status
);

	logic              first_beat;    // from the sender
	logic              timer_clear;   // reset or soft reset
	logic              timer_run;     // between first beat and first rx
	logic [DATA_W-1:0] latency_q;
	logic [DATA_W-1:0] rx_hist_q   [PKT_WORDS];
	logic [STAT_W-1:0] stat_hist_q [PKT_WORDS];

	packet_sender sender (
		.io_clk     (io_clk),
		.reset      (reset),
		.cfg        (cfg),
		.tx_ready   (tx_ready),
		.tx_data    (tx_data),
		.tx_valid   (tx_valid),
		.tx_last    (tx_last),
		.first_beat (first_beat)
	);

	////////////////////////////////////////////////////////////
	// receive and status history
	// newest enters the top slot, oldest falls out of slot 0
	always_ff @(posedge io_clk) begin
		if (reset) begin
			for (int i = 0; i < PKT_WORDS; i++) begin
				rx_hist_q[i]   <= '0;
				stat_hist_q[i] <= '0;
			end
		end else if (rx_valid) begin
			for (int i = 0; i < PKT_WORDS - 1; i++) begin
				rx_hist_q[i]   <= rx_hist_q[i+1];
				stat_hist_q[i] <= stat_hist_q[i+1];
			end
			rx_hist_q[PKT_WORDS-1]   <= rx_data;
			stat_hist_q[PKT_WORDS-1] <= {tx_ready, rx_valid, rx_last, link_status};
		end
	end

	////////////////////////////////////////////////////////////
	// latency timer
	// zero on the first transfer edge, +1 per edge, stop when rx_valid sampled
	assign timer_clear = reset | cfg.soft_reset;

	always_ff @(posedge io_clk) begin
		if (timer_clear) begin
			latency_q <= '0;
			timer_run <= 1'b0;
		end else if (first_beat) begin
			latency_q <= '0;
			timer_run <= ~rx_valid;  // rx in the same cycle means zero
		end else if (timer_run) begin
			if (latency_q != '1)
				latency_q <= latency_q + 1'b1;  // saturates at all ones
			if (rx_valid)
				timer_run <= 1'b0;  // frozen until the next packet
		end
	end

	assign rdbk.rx_hist   = rx_hist_q;
	assign rdbk.stat_hist = stat_hist_q;
	assign rdbk.latency   = latency_q;

endmodule

`default_nettype wire

/* rtl/link_rdbk_mux.sv */
`default_nettype none

module link_rdbk_mux import link_test_pkg::*; (
	input  wire logic              io_clk,
	input  wire logic              reset,
	input  wire logic              io_sel,
	input  wire logic              io_sync,
	input  wire logic [ADDR_W-1:0] io_addr,
	input  wire logic              io_rd_en,
	lane_cfg_if.rdbk               cfg  [NUM_LANES],
	lane_rdbk_if.rdbk              rdbk [NUM_LANES],
	output logic      [DATA_W-1:0] io_rd_data,
	output logic                   io_rd_ack
);

	logic              rd_req;    // qualified read strobe
	logic [DATA_W-1:0] rd_mux;    // selected word, zero if unmapped
	logic [DATA_W-1:0] pkt_word_w  [NUM_LANES][PKT_WORDS];
	logic [DATA_W-1:0] rx_hist_w   [NUM_LANES][PKT_WORDS];
	logic [STAT_W-1:0] stat_hist_w [NUM_LANES][PKT_WORDS];
	logic [DATA_W-1:0] latency_w   [NUM_LANES];

	assign rd_req = io_sync & io_sel & io_rd_en;

	// flatten the interface arrays
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_flat
		assign pkt_word_w[n]  = cfg[n].pkt_word;
		assign rx_hist_w[n]   = rdbk[n].rx_hist;
		assign stat_hist_w[n] = rdbk[n].stat_hist;
		assign latency_w[n]   = rdbk[n].latency;
	end

	////////////////////////////////////////////////////////////
	// read decode
	always_comb begin
		rd_mux = '0;
		for (int n = 0; n < NUM_LANES; n++) begin
			for (int w = 0; w < PKT_WORDS; w++) begin
				if (io_addr == lane_addr(n, OFS_PKT_WORD + w))
					rd_mux = pkt_word_w[n][w];
				if (io_addr == lane_addr(n, OFS_RX_HIST + w))
					rd_mux = rx_hist_w[n][w];
				if (io_addr == lane_addr(n, OFS_STAT_HIST + w))
					rd_mux = DATA_W'(stat_hist_w[n][w]);  // zero extended
			end
			if (io_addr == ADDR_W'(ADDR_LATENCY + n))
				rd_mux = latency_w[n];
		end
	end

	// one cycle latency, data held until the next read
	always_ff @(posedge io_clk) begin
		if (reset) begin
			io_rd_ack  <= 1'b0;
			io_rd_data <= '0;
		end else begin
			io_rd_ack <= rd_req;  // single cycle pulse
			if (rd_req)
				io_rd_data <= rd_mux;
		end
	end

endmodule

`default_nettype wire

/* rtl/link_test_block.sv */
`default_nettype none

module link_test_block import link_test_pkg::*; (
	input  wire logic                                  io_clk,
	input  wire logic                                  reset,
	// register bus
	input  wire logic                                  io_sel,
	input  wire logic                                  io_sync,
	input  wire logic [ADDR_W-1:0]                     io_addr,
	input  wire logic                                  io_rd_en,
	input  wire logic                                  io_wr_en,
	input  wire logic [DATA_W-1:0]                     io_wr_data,
	output logic      [DATA_W-1:0]                     io_rd_data,
	output logic                                       io_rd_ack,
	// tx streams, index is the lane
	output logic      [NUM_LANES-1:0][DATA_W-1:0]      tx_data,
	output logic      [NUM_LANES-1:0]                  tx_valid,
	output logic      [NUM_LANES-1:0]                  tx_last,
	input  wire logic [NUM_LANES-1:0]                  tx_ready,
	// rx streams and link status
	input  wire logic [NUM_LANES-1:0][DATA_W-1:0]      rx_data,
	input  wire logic [NUM_LANES-1:0]                  rx_valid,
	input  wire logic [NUM_LANES-1:0]                  rx_last,
	input  wire logic [NUM_LANES-1:0][LINK_STAT_W-1:0] link_status
);

	lane_cfg_if  cfg_if  [NUM_LANES] ();  // regs to lanes and readback
	lane_rdbk_if rdbk_if [NUM_LANES] ();  // lanes to readback

	////////////////////////////////////////////////////////////
	// register writes
	link_test_regs regs (
		.io_clk     (io_clk),
		.reset      (reset),
		.io_sel     (io_sel),
		.io_sync    (io_sync),
		.io_addr    (io_addr),
		.io_wr_en   (io_wr_en),
		.io_wr_data (io_wr_data),
		.cfg        (cfg_if)
	);

	////////////////////////////////////////////////////////////
	// lanes
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		link_lane lane (
			.io_clk      (io_clk),
			.reset       (reset),
			.cfg         (cfg_if[n]),
			.rdbk        (rdbk_if[n]),
			.tx_data     (tx_data[n]),
			.tx_valid    (tx_valid[n]),
			.tx_last     (tx_last[n]),
			.tx_ready    (tx_ready[n]),
			.rx_data     (rx_data[n]),
			.rx_valid    (rx_valid[n]),
			.rx_last     (rx_last[n]),
			.link_status (link_status[n])
		);
	end

	////////////////////////////////////////////////////////////
	// register reads
	link_rdbk_mux rdbk_mux (
		.io_clk     (io_clk),
		.reset      (reset),
		.io_sel     (io_sel),
		.io_sync    (io_sync),
		.io_addr    (io_addr),
		.io_rd_en   (io_rd_en),
		.cfg        (cfg_if),
		.rdbk       (rdbk_if),
		.io_rd_data (io_rd_data),
		.io_rd_ack  (io_rd_ack)
	);

endmodule

`default_nettype wire

/* sim/link_test_block_props.sv */
`default_nettype none

module link_test_block_props import link_test_pkg::*; (
	input wire logic                             io_clk,
	input wire logic                             reset,
	input wire logic                             io_sel,
	input wire logic                             io_sync,
	input wire logic                             io_rd_en,
	input wire logic                             io_rd_ack,
	input wire logic [NUM_LANES-1:0][DATA_W-1:0] tx_data,
	input wire logic [NUM_LANES-1:0]             tx_valid,
	input wire logic [NUM_LANES-1:0]             tx_last,
	input wire logic [NUM_LANES-1:0]             tx_ready
);

	int unsigned fail_count = 0;  // assertion failures so far
	logic        rd_req;          // qualified read strobe

	assign rd_req = io_sync & io_sel & io_rd_en;

	////////////////////////////////////////////////////////////
	// read ack one cycle after a request and only then
	ack_after_req: assert property (@(posedge io_clk) disable iff (reset)
		rd_req |=> io_rd_ack)
		else begin
			$error("io_rd_ack missing one cycle after a read request");
			fail_count++;
		end

	ack_only_req: assert property (@(posedge io_clk) disable iff (reset)
		!rd_req |=> !io_rd_ack)
		else begin
			$error("io_rd_ack without a read request");
			fail_count++;
		end

	// sender idle right after reset
	valid_after_reset: assert property (@(posedge io_clk)
		reset |=> (tx_valid == '0))
		else begin
			$error("tx_valid high in the cycle after reset");
			fail_count++;
		end

	////////////////////////////////////////////////////////////
	// stream word held under back-pressure
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		tx_hold: assert property (@(posedge io_clk) disable iff (reset)
			tx_valid[n] && !tx_ready[n] |=> $stable(tx_data[n]) && $stable(tx_last[n]))
			else begin
				$error("tx word of lane %0d changed while stalled", n);
				fail_count++;
			end
	end

endmodule

bind link_test_block link_test_block_props props (.*);

`default_nettype wire

/* sim/link_test_block_tb.sv */
`default_nettype none

module link_test_block_tb import link_test_pkg::*; ();

	localparam int MAX_CYCLES = 4000;  // about four times the summed test length
	localparam int WAIT_LIMIT = 200;   // cycles for one wait on the link
	localparam int RING       = 64;    // loop delay slots
	localparam int LOG_DEPTH  = 16;    // sent words kept per lane

	logic                                  io_clk;
	logic                                  reset;
	logic                                  io_sel;
	logic                                  io_sync;
	logic                                  io_rd_en;
	logic                                  io_wr_en;
	logic [ADDR_W-1:0]                     io_addr;
	logic [DATA_W-1:0]                     io_wr_data;
	logic [DATA_W-1:0]                     io_rd_data;
	logic                                  io_rd_ack;
	logic [NUM_LANES-1:0][DATA_W-1:0]      tx_data;
	logic [NUM_LANES-1:0]                  tx_valid;
	logic [NUM_LANES-1:0]                  tx_last;
	logic [NUM_LANES-1:0]                  tx_ready;
	logic [NUM_LANES-1:0][DATA_W-1:0]      rx_data;
	logic [NUM_LANES-1:0]                  rx_valid;
	logic [NUM_LANES-1:0]                  rx_last;
	logic [NUM_LANES-1:0][LINK_STAT_W-1:0] link_status;

	int                cyc = 0;
	int                errors;
	int                err_mark;    // errors at the start of a test
	int                tests;
	int                seed;
	logic [DATA_W-1:0] pkt        [NUM_LANES][PKT_WORDS];  // words written per lane
	int                ready_mode [NUM_LANES];  // 0 ready, 1 random stalls, 2 stalled
	int                loop_delay [NUM_LANES];  // tx to rx in cycles
	int                sent_cnt   [NUM_LANES];
	int                rx_cnt     [NUM_LANES];
	logic [DATA_W-1:0] sent_data  [NUM_LANES][LOG_DEPTH];
	logic              sent_last  [NUM_LANES][LOG_DEPTH];
	logic              ring_valid [NUM_LANES][RING];
	logic [DATA_W-1:0] ring_data  [NUM_LANES][RING];
	logic              ring_last  [NUM_LANES][RING];

	link_test_block dut (.*);

	initial begin
		io_clk = 1'b0;
		forever #20 io_clk = ~io_clk;
	end

	always @(posedge io_clk) cyc <= cyc + 1;

	initial begin
		wait (cyc >= MAX_CYCLES);
		$display("timeout after %0d cycles, the tests did not finish", cyc);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// link model looping tx back to rx of the same lane
	task automatic link_model();
		int slot;
		for (int n = 0; n < NUM_LANES; n++)
			for (int s = 0; s < RING; s++)
				ring_valid[n][s] = 1'b0;
		forever begin
			@(posedge io_clk);
			for (int n = 0; n < NUM_LANES; n++) begin
				if (tx_valid[n] && tx_ready[n]) begin  // accepted word
					slot = (cyc + loop_delay[n] - 1) % RING;  // rx sampled D edges later
					ring_valid[n][slot] = 1'b1;
					ring_data[n][slot]  = tx_data[n];
					ring_last[n][slot]  = tx_last[n];
					if (sent_cnt[n] < LOG_DEPTH) begin
						sent_data[n][sent_cnt[n]] = tx_data[n];
						sent_last[n][sent_cnt[n]] = tx_last[n];
					end
					sent_cnt[n]++;
				end
				slot = cyc % RING;
				rx_valid[n] <= ring_valid[n][slot];
				rx_data[n]  <= ring_valid[n][slot] ? ring_data[n][slot] : '0;
				rx_last[n]  <= ring_valid[n][slot] & ring_last[n][slot];
				if (ring_valid[n][slot])
					rx_cnt[n]++;
				ring_valid[n][slot] = 1'b0;
				case (ready_mode[n])
					0:       tx_ready[n] <= 1'b1;
					1:       tx_ready[n] <= (($random(seed) & 3) != 0);  // stall one in four
					default: tx_ready[n] <= 1'b0;
				endcase
			end
		end
	endtask

	initial link_model();

	////////////////////////////////////////////////////////////
	// bus access
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge io_clk);
		io_sync    <= 1'b1;
		io_sel     <= 1'b1;
		io_wr_en   <= 1'b1;
		io_addr    <= addr;
		io_wr_data <= data;
		@(posedge io_clk);  // stored on this edge
		io_sync    <= 1'b0;
		io_sel     <= 1'b0;
		io_wr_en   <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		int waits;
		@(posedge io_clk);
		io_sync  <= 1'b1;
		io_sel   <= 1'b1;
		io_rd_en <= 1'b1;
		io_addr  <= addr;
		@(posedge io_clk);
		io_sync  <= 1'b0;
		io_sel   <= 1'b0;
		io_rd_en <= 1'b0;
		waits = 0;
		@(negedge io_clk);
		while (!io_rd_ack && waits < 4) begin
			@(negedge io_clk);
			waits++;
		end
		if (!io_rd_ack) begin
			errors++;
			$display("no read acknowledge for address 0x%h", addr);
		end else if (waits != 0) begin
			errors++;
			$display("read acknowledge for 0x%h came %0d cycles late", addr, waits);
		end
		data = io_rd_data;
	endtask

	task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] got;
		bus_read(addr, got);
		if (got !== exp) begin
			errors++;
			$display("mismatch io_rd_data at 0x%h: got 0x%h, expected 0x%h", addr, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// link control and waits
	task automatic setup_link(input int mode, input int d0, input int d1);
		@(negedge io_clk);
		for (int n = 0; n < NUM_LANES; n++) begin
			ready_mode[n] = mode;
			sent_cnt[n]   = 0;
			rx_cnt[n]     = 0;
		end
		loop_delay[0] = d0;
		loop_delay[1] = d1;
	endtask

	// kind 0 sent words, 1 received words, 2 tx_valid up on both lanes
	task automatic wait_link(input int kind, input int words);
		int t;
		t = 0;
		while (t < WAIT_LIMIT && !((kind == 0 && sent_cnt[0] >= words && sent_cnt[1] >= words) ||
			(kind == 1 && rx_cnt[0] >= words && rx_cnt[1] >= words) ||
			(kind == 2 && tx_valid == '1))) begin
			@(negedge io_clk);
			t++;
		end
		if (t >= WAIT_LIMIT) begin
			errors++;
			$display("timed out waiting on the link, kind %0d, %0d words", kind, words);
		end
	endtask

	// sent words from index first must be one packet in order
	task automatic check_packets(input int first);
		for (int n = 0; n < NUM_LANES; n++) begin
			for (int w = 0; w < PKT_WORDS; w++) begin
				if (sent_data[n][first+w] !== pkt[n][w]) begin
					errors++;
					$display("mismatch tx_data[%0d] word %0d: got 0x%h, expected 0x%h",
						n, first + w, sent_data[n][first+w], pkt[n][w]);
				end
				if (sent_last[n][first+w] !== (w == PKT_WORDS - 1)) begin
					errors++;
					$display("mismatch tx_last[%0d] word %0d: got 0x%h, expected 0x%h",
						n, first + w, sent_last[n][first+w], (w == PKT_WORDS - 1));
				end
			end
		end
	endtask

	task automatic test_done(input string name);
		if (errors == err_mark)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_mark);
		tests++;
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////
	// tests
	task automatic test_reg_readback();
		check_read(lane_addr(1, OFS_PKT_WORD), '0);  // cleared by reset
		check_read(ADDR_W'(ADDR_LATENCY), '0);
		for (int n = 0; n < NUM_LANES; n++) begin
			for (int w = 0; w < PKT_WORDS; w++) begin
				pkt[n][w] = $random(seed);
				bus_write(lane_addr(n, OFS_PKT_WORD + w), pkt[n][w]);
			end
		end
		for (int n = 0; n < NUM_LANES; n++)
			for (int w = 0; w < PKT_WORDS; w++)
				check_read(lane_addr(n, OFS_PKT_WORD + w), pkt[n][w]);
		check_read(16'h0100, '0);
		test_done("register readback");
	endtask

	task automatic test_backpressure();
		setup_link(1, 3, 3);
		bus_write(ADDR_LANE_EN, 32'h3);
		check_read(ADDR_LANE_EN, '0);  // enable register is write only
		wait_link(0, PKT_WORDS);
		repeat (20) @(negedge io_clk);  // room for a stray fourth word
		check_packets(0);
		for (int n = 0; n < NUM_LANES; n++) begin
			if (sent_cnt[n] != PKT_WORDS) begin
				errors++;
				$display("lane %0d sent %0d words while one packet was expected", n, sent_cnt[n]);
			end
		end
		bus_write(ADDR_LANE_EN, 32'h0);  // rearm
		bus_write(ADDR_LANE_EN, 32'h3);
		wait_link(0, 2 * PKT_WORDS);
		check_packets(PKT_WORDS);
		bus_write(ADDR_LANE_EN, 32'h0);
		wait_link(1, 2 * PKT_WORDS);  // drain the loop
		test_done("packet send under back-pressure");
	endtask

	task automatic test_rx_history();
		logic [STAT_W-1:0] stat_exp;
		setup_link(0, 2, 5);
		for (int n = 0; n < NUM_LANES; n++) begin
			for (int w = 0; w < PKT_WORDS; w++) begin
				pkt[n][w] = $random(seed);  // new payload for this packet
				bus_write(lane_addr(n, OFS_PKT_WORD + w), pkt[n][w]);
			end
		end
		@(posedge io_clk);
		for (int n = 0; n < NUM_LANES; n++)
			link_status[n] <= LINK_STAT_W'($random(seed));
		bus_write(ADDR_LANE_EN, 32'h3);
		wait_link(1, PKT_WORDS);
		repeat (2) @(negedge io_clk);  // last rx word captured
		for (int n = 0; n < NUM_LANES; n++) begin
			for (int w = 0; w < PKT_WORDS; w++) begin
				check_read(lane_addr(n, OFS_RX_HIST + w), pkt[n][w]);
				// ready, valid, last on newest only, link status
				stat_exp = {1'b1, 1'b1, (w == PKT_WORDS - 1), link_status[n]};
				check_read(lane_addr(n, OFS_STAT_HIST + w), DATA_W'(stat_exp));
			end
		end
		bus_write(ADDR_LANE_EN, 32'h0);
		test_done("receive history");
	endtask

	task automatic test_latency();
		setup_link(0, 4, 7);
		bus_write(ADDR_LANE_EN, 32'h3);
		wait_link(1, PKT_WORDS);
		for (int n = 0; n < NUM_LANES; n++)
			check_read(ADDR_W'(ADDR_LATENCY + n), loop_delay[n]);
		repeat (10) @(negedge io_clk);
		for (int n = 0; n < NUM_LANES; n++)
			check_read(ADDR_W'(ADDR_LATENCY + n), loop_delay[n]);  // still frozen
		bus_write(ADDR_LANE_EN, 32'h0);
		test_done("latency");
	endtask

	task automatic test_soft_reset();
		setup_link(2, 4, 7);  // ready low so packets stick on word 1
		bus_write(ADDR_LANE_EN, 32'h3);
		wait_link(2, 0);
		bus_write(ADDR_SOFT_RESET, 32'h1);
		repeat (2) @(negedge io_clk);
		if (tx_valid !== '0) begin
			errors++;
			$display("mismatch tx_valid after soft reset: got 0x%h, expected 0x0", tx_valid);
		end
		for (int n = 0; n < NUM_LANES; n++) begin
			check_read(ADDR_W'(ADDR_LATENCY + n), '0);
			for (int w = 0; w < PKT_WORDS; w++) begin
				check_read(lane_addr(n, OFS_RX_HIST + w), pkt[n][w]);  // history kept
				check_read(lane_addr(n, OFS_PKT_WORD + w), pkt[n][w]);
			end
		end
		if (tx_valid !== '0) begin  // held while the bit stays set
			errors++;
			$display("mismatch tx_valid during soft reset: got 0x%h, expected 0x0", tx_valid);
		end
		bus_write(ADDR_LANE_EN, 32'h0);
		bus_write(ADDR_SOFT_RESET, 32'h0);
		setup_link(0, 4, 7);
		bus_write(ADDR_LANE_EN, 32'h3);
		wait_link(0, PKT_WORDS);
		repeat (2) @(negedge io_clk);
		check_packets(0);
		bus_write(ADDR_LANE_EN, 32'h0);
		test_done("soft reset");
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		seed       = 32'h0e54_ff7e;
		errors     = 0;
		err_mark   = 0;
		tests      = 0;
		reset      = 1'b1;
		io_sel     = 1'b0;
		io_sync    = 1'b0;
		io_rd_en   = 1'b0;
		io_wr_en   = 1'b0;
		io_addr    = '0;
		io_wr_data = '0;
		tx_ready   = '1;
		rx_data    = '0;
		rx_valid   = '0;
		rx_last    = '0;
		link_status = '0;
		for (int n = 0; n < NUM_LANES; n++) begin
			ready_mode[n] = 0;
			loop_delay[n] = 1;
			sent_cnt[n]   = 0;
			rx_cnt[n]     = 0;
		end
		repeat (8) @(posedge io_clk);
		reset <= 1'b0;
		test_reg_readback();
		test_backpressure();
		test_rx_history();
		test_latency();
		test_soft_reset();
		if (dut.props.fail_count != 0) begin
			errors += dut.props.fail_count;
			$display("%0d assertion failures on bus and stream rules", dut.props.fail_count);
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* link_test_block.f */
rtl/link_test_pkg.sv
rtl/lane_if.sv
rtl/link_test_regs.sv
rtl/packet_sender.sv
rtl/link_lane.sv
rtl/link_rdbk_mux.sv
rtl/link_test_block.sv
sim/link_test_block_props.sv
sim/link_test_block_tb.sv

/* Bender.yml */
package:
  name: link_test_block

sources:
  - rtl/link_test_pkg.sv
  - rtl/lane_if.sv
  - rtl/link_test_regs.sv
  - rtl/packet_sender.sv
  - rtl/link_lane.sv
  - rtl/link_rdbk_mux.sv
  - rtl/link_test_block.sv
  - target: simulation
    files:
      - sim/link_test_block_props.sv
      - sim/link_test_block_tb.sv
